/* build.f */
+incdir+tb
logic/dcache_pkg.sv
logic/dcache_way.sv
logic/dcache_way_select.sv
logic/dcache_top.sv
tb/dcache_tb.sv

/* Bender.yml */
package:
  name: dcache

sources:
  # Synthesizable cache, package first
  - files:
      - logic/dcache_pkg.sv
      - logic/dcache_way.sv
      - logic/dcache_way_select.sv
      - logic/dcache_top.sv

  # Testbench with its model header
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/dcache_tb.sv

# Top modules: dcache_tb for simulation, dcache_top for the design

/* tb/dcache_model.svh */
`ifndef DCACHE_MODEL_SVH
`define DCACHE_MODEL_SVH

// Reference model, lives inside the testbench module
localparam int M_IDX_W   = $clog2(SET_NUM);              // Set index bits
localparam int M_TAG_W   = ADDR_W - M_IDX_W;             // Tag bits
localparam int MEM_IDX_W = 6;                            // Testbench addresses stay below 64
localparam int MEM_WORDS = 2 ** MEM_IDX_W;

logic [DATA_W-1:0]  m_mem     [MEM_WORDS];               // Written memory words
logic               m_written [MEM_WORDS];               // Word has seen a store
logic               m_valid   [SET_NUM][2];              // Valid per set and way
logic [M_TAG_W-1:0] m_tag     [SET_NUM][2];              // Tag per set and way
logic               m_lru     [SET_NUM];                 // Next victim per set

// Memory word, untouched words follow the fill pattern
function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
  if (m_written[addr[MEM_IDX_W-1:0]]) begin
    return m_mem[addr[MEM_IDX_W-1:0]];
  end
  return addr ^ 32'hA5A5_0000;                           // Depends on every address bit
endfunction

// Way holding the tag, or -1 on a miss
function automatic int find_way(input logic [ADDR_W-1:0] addr);
  int                 s;
  logic [M_TAG_W-1:0] t;
  s = addr[M_IDX_W-1:0];
  t = addr[ADDR_W-1:M_IDX_W];
  for (int w = 0; w < 2; w++) begin
    if (m_valid[s][w] && (m_tag[s][w] == t)) begin
      return w;
    end
  end
  return -1;
endfunction

// Empty cache, way 0 first, memory at its fill pattern
function automatic void model_reset();
  for (int s = 0; s < SET_NUM; s++) begin
    m_lru[s] = 1'b0;
    for (int w = 0; w < 2; w++) begin
      m_valid[s][w] = 1'b0;
      m_tag[s][w]   = '0;
    end
  end
  for (int i = 0; i < MEM_WORDS; i++) begin
    m_written[i] = 1'b0;
    m_mem[i]     = '0;
  end
endfunction

// State change at the clock edge after one request
function automatic void model_update(input logic ld, input logic st,
                                     input logic [ADDR_W-1:0] addr,
                                     input logic [DATA_W-1:0] wd);
  int                s;
  int                w;
  logic [DATA_W-1:0] word;
  if (!(ld || st)) begin
    return;                                              // Idle leaves all state alone
  end
  s = addr[M_IDX_W-1:0];
  w = find_way(addr);
  if (w < 0) begin
    w             = m_lru[s];                            // Miss takes the LRU way
    m_valid[s][w] = 1'b1;
    m_tag[s][w]   = addr[ADDR_W-1:M_IDX_W];
  end
  m_lru[s] = (w == 0);                                   // Other way is next victim
  if (st) begin
    word                          = mem_word(addr);
    word[BYTE_W-1:0]              = wd[BYTE_W-1:0];      // Write-through of the low byte
    m_mem[addr[MEM_IDX_W-1:0]]     = word;
    m_written[addr[MEM_IDX_W-1:0]] = 1'b1;
  end
endfunction

`endif

/* tb/dcache_tb.sv */
`timescale 1ns/1ns

module dcache_tb;

  import dcache_pkg::*;

  localparam int SET_NUM      = 8;                       // Sets in DUT and model
  localparam int TAG_NUM      = 4;                       // Tags used, many conflicts
  localparam int RANDOM_OPS   = 2000;                    // Length of the random mix
  localparam int DIRECTED_OPS = 40;                      // Bound on directed cycles
  localparam int CLK_PERIOD   = 20;

  logic              clk;
  logic              arst_n;
  cache_req_t        req;                                // Memory stage request
  logic [DATA_W-1:0] rd_data;
  logic              hit;
  logic [ADDR_W-1:0] mem_addr;
  logic [DATA_W-1:0] mem_rdata;                          // Answered by the model memory
  logic              mem_we;
  logic [DATA_W-1:0] mem_wdata;
  integer            seed;                               // $random state

  `include "dcache_model.svh"

  dcache_top #(
    .SET_NUM (SET_NUM)
  ) dcache_top_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .req       (req),
    .rd_data   (rd_data),
    .hit       (hit),
    .mem_addr  (mem_addr),
    .mem_rdata (mem_rdata),
    .mem_we    (mem_we),
    .mem_wdata (mem_wdata)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;                   // 20 ns period

  // Print the reason, then end the run
  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
    assert (actual === expected) else begin
      stop_run($sformatf("** Error: %s expected 0x%0h, got 0x%0h", name, expected, actual));
    end
  endtask

  function automatic logic [ADDR_W-1:0] make_addr(input int tag, input int set_i);
    return ADDR_W'(tag * SET_NUM + set_i);               // Set in the low bits
  endfunction

  // One request cycle, entered 2 ns after a rising edge
  task automatic run_op(input logic ld, input logic st, input logic [ADDR_W-1:0] addr,
                        input logic [DATA_W-1:0] wd, output logic hit_seen,
                        output logic [DATA_W-1:0] rd_seen);
    logic              exp_hit;
    logic [DATA_W-1:0] word;
    logic [DATA_W-1:0] exp_rd;
    req.load  = ld;
    req.store = st;
    req.addr  = addr;
    req.wdata = wd;
    word      = mem_word(addr);
    mem_rdata = word;                                    // Same-cycle memory answer
    exp_hit   = (ld || st) && (find_way(addr) >= 0);
    exp_rd    = '0;
    if (ld) begin
      exp_rd[BYTE_W-1:0] = word[BYTE_W-1:0];             // Write-through keeps memory current
    end
    #(CLK_PERIOD - 3);                                   // Sample just before the edge
    check_value("hit", exp_hit, hit);
    check_value("rd_data", exp_rd, rd_data);
    check_value("mem_we", st, mem_we);
    check_value("mem_addr", addr, mem_addr);
    if (st) begin
      check_value("mem_wdata", wd, mem_wdata);
    end
    hit_seen = hit;
    rd_seen  = rd_data;
    @(posedge clk);
    model_update(ld, st, addr, wd);                      // DUT updates at the same edge
    #2;
  endtask

  initial begin
    logic              h;
    logic [DATA_W-1:0] rd;
    logic [ADDR_W-1:0] addr_a;
    logic [ADDR_W-1:0] addr_b;
    logic [ADDR_W-1:0] addr_c;
    logic [ADDR_W-1:0] addr_d;
    logic [DATA_W-1:0] wd_a;
    logic [DATA_W-1:0] wd_d;
    int                op;
    int                tag;
    int                set_i;
    seed      = 17;
    clk       = 1'b0;
    arst_n    = 1'b0;
    req       = '0;
    mem_rdata = '0;
    model_reset();
    repeat (2) @(posedge clk);                           // Reset held for 2 cycles
    #2;
    arst_n = 1'b1;

    // Idle after reset, then a cold miss and a repeat hit
    repeat (3) run_op(1'b0, 1'b0, '0, '0, h, rd);
    addr_a = make_addr(1, 3);
    run_op(1'b1, 1'b0, addr_a, '0, h, rd);
    check_value("hit", 0, h);
    run_op(1'b1, 1'b0, addr_a, '0, h, rd);
    check_value("hit", 1, h);

    // LRU order A, B, A, C in set 5
    addr_a = make_addr(0, 5);
    addr_b = make_addr(1, 5);
    addr_c = make_addr(2, 5);
    run_op(1'b1, 1'b0, addr_a, '0, h, rd);
    run_op(1'b1, 1'b0, addr_b, '0, h, rd);
    run_op(1'b1, 1'b0, addr_a, '0, h, rd);
    run_op(1'b1, 1'b0, addr_c, '0, h, rd);               // C evicts B
    run_op(1'b1, 1'b0, addr_a, '0, h, rd);
    check_value("hit", 1, h);
    run_op(1'b1, 1'b0, addr_b, '0, h, rd);
    check_value("hit", 0, h);

    // Store hit on A, store miss on D, then read both back
    wd_a   = $random(seed);
    wd_d   = $random(seed);
    addr_d = make_addr(3, 5);
    run_op(1'b0, 1'b1, addr_a, wd_a, h, rd);
    check_value("hit", 1, h);
    run_op(1'b0, 1'b1, addr_d, wd_d, h, rd);
    check_value("hit", 0, h);
    run_op(1'b1, 1'b0, addr_d, '0, h, rd);
    check_value("rd_data", {24'h0, wd_d[7:0]}, rd);
    run_op(1'b1, 1'b0, addr_a, '0, h, rd);
    check_value("rd_data", {24'h0, wd_a[7:0]}, rd);

    // Random mix: quarter idle, half loads, quarter stores
    for (int i = 0; i < RANDOM_OPS; i++) begin
      op     = {$random(seed)} % 4;
      tag    = {$random(seed)} % TAG_NUM;
      set_i  = {$random(seed)} % SET_NUM;
      wd_a   = $random(seed);
      addr_a = make_addr(tag, set_i);
      run_op((op == 1) || (op == 2), op == 3, addr_a, wd_a, h, rd);
    end

    $display("All tests passed!");
    $finish;
  end

  // Watchdog sized from the number of request cycles
  initial begin
    #((RANDOM_OPS + DIRECTED_OPS + 50) * CLK_PERIOD);
    stop_run("Timeout: the test sequence did not finish in time");
  end

endmodule

/* logic/dcache_top.sv */
`timescale 1ns/1ns

module dcache_top #(
  parameter int SET_NUM = 8                                  // Number of sets, power of two
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  dcache_pkg::cache_req_t        req,                 // From memory stage
  output logic [dcache_pkg::DATA_W-1:0] rd_data,             // Load byte, zero-extended
  output logic                          hit,                 // Access hit
  output logic [dcache_pkg::ADDR_W-1:0] mem_addr,            // Memory word address
  input  logic [dcache_pkg::DATA_W-1:0] mem_rdata,           // Memory answers same cycle
  output logic                          mem_we,              // Write-through strobe
  output logic [dcache_pkg::DATA_W-1:0] mem_wdata            // Write-through data
);

  import dcache_pkg::*;

  localparam int IDX_W = $clog2(SET_NUM);                    // Set index bits
  localparam int TAG_W = ADDR_W - IDX_W;                     // Tag bits

  // Address split
  logic [IDX_W-1:0] set_idx;                                 // Low address bits
  logic [TAG_W-1:0] tag_in;                                  // Upper address bits

  // Way interconnect
  way_result_t [WAY_NUM-1:0] way_res;                        // Lookups into select block
  way_cmd_t    [WAY_NUM-1:0] way_cmd;                        // Writes back to the ways

  assign set_idx = req.addr[IDX_W-1:0];
  assign tag_in  = req.addr[ADDR_W-1:IDX_W];

  // Every access goes to memory, stores write through
  assign mem_addr  = req.addr;
  assign mem_we    = req.store;
  assign mem_wdata = req.wdata;

  // Way 0
  dcache_way #(
    .SET_NUM (SET_NUM)
  ) way0_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .set_idx (set_idx),
    .tag_in  (tag_in),
    .cmd     (way_cmd[0]),
    .result  (way_res[0])
  );

  // Way 1, looked up in parallel
  dcache_way #(
    .SET_NUM (SET_NUM)
  ) way1_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .set_idx (set_idx),
    .tag_in  (tag_in),
    .cmd     (way_cmd[1]),
    .result  (way_res[1])
  );

  // Hit detect, load data, LRU and way writes
  dcache_way_select #(
    .SET_NUM (SET_NUM)
  ) way_select_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .req       (req),
    .set_idx   (set_idx),
    .ways      (way_res),
    .mem_rdata (mem_rdata),
    .cmds      (way_cmd),
    .rd_data   (rd_data),
    .hit       (hit)
  );

endmodule

/* logic/dcache_way_select.sv */
`timescale 1ns/1ns

module dcache_way_select #(
  parameter int SET_NUM = 8                                        // Number of sets
) (
  input  logic                                                 clk,
  input  logic                                                 arst_n,
  input  dcache_pkg::cache_req_t                               req,       // Current access
  input  logic [$clog2(SET_NUM)-1:0]                           set_idx,   // Addressed set
  input  dcache_pkg::way_result_t [dcache_pkg::WAY_NUM-1:0]    ways,      // Way lookups
  input  logic [dcache_pkg::DATA_W-1:0]                        mem_rdata, // Memory word
  output dcache_pkg::way_cmd_t [dcache_pkg::WAY_NUM-1:0]       cmds,      // Way writes
  output logic [dcache_pkg::DATA_W-1:0]                        rd_data,   // Load result
  output logic                                                 hit        // Access hit
);

  import dcache_pkg::*;

  localparam int WAY_IDX_W = $clog2(WAY_NUM);                      // One bit for two ways

  // Replacement state, one LRU way index per set
  logic [SET_NUM-1:0][WAY_IDX_W-1:0] lru_q;

  // Access decode
  logic                 access;                                    // Load or store this cycle
  logic [WAY_NUM-1:0]   match_vec;                                 // Per-way match flags
  logic                 any_match;                                 // Some way holds the tag
  logic [WAY_IDX_W-1:0] hit_way;                                   // Index of matching way
  logic [WAY_IDX_W-1:0] victim;                                    // LRU way of the set
  logic [WAY_IDX_W-1:0] use_way;                                   // Way touched by access

  // Data paths
  logic [BYTE_W-1:0]    hit_byte;                                  // Low byte from the cache
  logic [BYTE_W-1:0]    mem_byte;                                  // Low byte from memory
  logic [DATA_W-1:0]    merged;                                    // Memory word, new low byte

  assign access = req.load | req.store;

  // Gather the match flags from both ways
  always_comb begin
    for (int w = 0; w < WAY_NUM; w++) begin
      match_vec[w] = ways[w].match;
    end
  end

  assign any_match = |match_vec;
  assign hit       = access & any_match;                           // No hit when idle

  // Encode the matching way, at most one is set
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < WAY_NUM; w++) begin
      if (match_vec[w]) begin
        hit_way = WAY_IDX_W'(w);
      end
    end
  end

  assign victim  = lru_q[set_idx];                                 // Way named by the LRU bit
  assign use_way = hit ? hit_way : victim;                         // Hit way, else victim

  // Byte sources for the load result
  assign hit_byte = ways[hit_way].data[BYTE_W-1:0];
  assign mem_byte = mem_rdata[BYTE_W-1:0];

  // Store miss allocates memory word with the store byte on top
  assign merged = {mem_rdata[DATA_W-1:BYTE_W], req.wdata[BYTE_W-1:0]};

  // Load data, zero-extended low byte
  always_comb begin
    rd_data = '0;                                                  // Zero when not loading
    if (req.load) begin
      if (hit) begin
        rd_data[BYTE_W-1:0] = hit_byte;                            // From the cache
      end else begin
        rd_data[BYTE_W-1:0] = mem_byte;                            // Same-cycle memory word
      end
    end
  end

  // Way commands
  always_comb begin
    for (int w = 0; w < WAY_NUM; w++) begin
      cmds[w] = '0;                                                // No write by default
    end
    if (req.load && !hit) begin
      cmds[victim].fill  = 1'b1;                                   // Load miss refills victim
      cmds[victim].wdata = mem_rdata;
    end else if (req.store && hit) begin
      cmds[hit_way].byte_we = 1'b1;                                // Store hit, byte only
      cmds[hit_way].wdata   = req.wdata;
    end else if (req.store) begin
      cmds[victim].fill  = 1'b1;                                   // Store miss allocates
      cmds[victim].wdata = merged;
    end
  end

  // LRU update: the used way becomes most recent, the other one is next victim
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lru_q <= '0;                                                 // Way 0 goes first
    end else if (access) begin
      lru_q[set_idx] <= ~use_way;                                  // Other of two ways
    end
  end

  // Processor side never issues load and store together
  a_req_excl : assert property (
    @(posedge clk) disable iff (!arst_n)
    !(req.load && req.store)
  ) else $error("dcache_way_select: load and store both high");

  // Fills always go to a single victim, so a tag lives in one way only
  a_match_onehot : assert property (
    @(posedge clk) disable iff (!arst_n)
    $onehot0(match_vec)
  ) else $error("dcache_way_select: both ways match the same tag");

endmodule

/* logic/dcache_way.sv */
`timescale 1ns/1ns

module dcache_way #(
  parameter int SET_NUM = 8                                  // Number of sets
) (
  input  logic                                           clk,
  input  logic                                           arst_n,
  input  logic [$clog2(SET_NUM)-1:0]                     set_idx, // Addressed set
  input  logic [dcache_pkg::ADDR_W-$clog2(SET_NUM)-1:0]  tag_in,  // Request tag
  input  dcache_pkg::way_cmd_t                           cmd,     // Write for this way
  output dcache_pkg::way_result_t                        result   // Lookup of this way
);

  import dcache_pkg::*;

  localparam int IDX_W = $clog2(SET_NUM);                    // Set index bits
  localparam int TAG_W = ADDR_W - IDX_W;                     // Remaining address bits

  // Line state
  logic [SET_NUM-1:0] valid_q;                               // One valid bit per set
  logic [TAG_W-1:0]   tag_q  [SET_NUM];                      // Tag per set
  logic [DATA_W-1:0]  data_q [SET_NUM];                      // Word per set

  // Lookup signals
  logic               set_valid;                             // Valid bit of addressed set
  logic [TAG_W-1:0]   set_tag;                               // Stored tag of addressed set
  logic               tag_eq;                                // Stored tag equals request

  // Lookup is purely combinational
  assign set_valid = valid_q[set_idx];
  assign set_tag   = tag_q[set_idx];
  assign tag_eq    = (set_tag == tag_in);

  always_comb begin
    result       = '0;
    result.match = set_valid && tag_eq;                      // Invalid lines never match
    result.data  = data_q[set_idx];                          // Word goes out on hit or miss
  end

  // Valid bits are the only state cleared at reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;                                         // Cache starts empty
    end else if (cmd.fill) begin
      valid_q[set_idx] <= 1'b1;                              // Fill allocates the line
    end
  end

  // Tag array
  always_ff @(posedge clk) begin
    if (cmd.fill) begin
      tag_q[set_idx] <= tag_in;                              // New owner of the set
    end
  end

  // Data array, whole word on fill or low byte on a store hit
  always_ff @(posedge clk) begin
    if (cmd.fill) begin
      data_q[set_idx] <= cmd.wdata;                          // Memory word, maybe merged
    end else if (cmd.byte_we) begin
      data_q[set_idx][BYTE_W-1:0] <= cmd.wdata[BYTE_W-1:0];  // Upper bytes kept
    end
  end

  // The select block must never ask for both writes at once
  a_fill_byte_excl : assert property (
    @(posedge clk) disable iff (!arst_n)
    !(cmd.fill && cmd.byte_we)
  ) else $error("dcache_way: fill and byte write in the same cycle");

  // A byte write only makes sense on a line that matched this cycle
  a_byte_on_match : assert property (
    @(posedge clk) disable iff (!arst_n)
    cmd.byte_we |-> result.match
  ) else $error("dcache_way: byte write to a line that does not match");

endmodule

/* logic/dcache_pkg.sv */
package dcache_pkg;

  // Widths shared by all cache blocks
  localparam int ADDR_W  = 32;             // Word address width
  localparam int DATA_W  = 32;             // One word per line
  localparam int BYTE_W  = 8;              // Only the low byte is loaded or stored
  localparam int WAY_NUM = 2;              // Two-way set associative

  // One access from the memory stage, a level strobe for one cycle
  typedef struct packed {
    logic              load;               // Load strobe
    logic              store;              // Store strobe, never with load
    logic [ADDR_W-1:0] addr;               // Word address, set index in the low bits
    logic [DATA_W-1:0] wdata;              // Store data, low byte used
  } cache_req_t;

  // What one way reports for the addressed set
  typedef struct packed {
    logic              match;              // Valid and tag equal
    logic [DATA_W-1:0] data;               // Stored word of the set
  } way_result_t;

  // Write command into one way, applied at the next edge
  typedef struct packed {
    logic              fill;               // Write word, tag and valid
    logic              byte_we;            // Replace low byte only
    logic [DATA_W-1:0] wdata;              // Fill word, or byte in the low bits
  } way_cmd_t;

  // A fill allocates the line for the current tag.
  // A byte write only touches a line that already matched.
  // The two strobes are exclusive per way and per cycle.

endpackage
